/* filelist.f */
+incdir+rtl
rtl/dmr_recovery_pkg.sv
rtl/dmr_error_capture.sv
rtl/dmr_recovery_seq.sv
rtl/dmr_rf_restore.sv
rtl/dmr_recovery_top.sv
tests/tb_dmr_core_model.sv
tests/tb_dmr_recovery.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_dmr_recovery
FILELIST  = filelist.f
BUILD_DIR = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf $(BUILD_DIR)

/* tests/tb_dmr_recovery.sv */
// dmr recovery testbench with stimulus, reference model and concurrent checks
`timescale 1ns/100ps

`include "dmr_recovery_cfg.svh"

module tb_dmr_recovery;

  import dmr_recovery_pkg::*;

  localparam int HALF      = 1 << (`DMR_RF_ADDR_WIDTH - 1);
  localparam int PC_CYCLES = `DMR_PC_RESTORE_CYCLES;
  // one recovery takes well under this many cycles
  localparam int WAIT_MAX  = 200;

  logic       clk_i;
  logic       rst_ni;
  group_vec_t err_rf_a_i;
  group_vec_t err_rf_b_i;
  group_vec_t err_core_main_i;
  group_vec_t err_core_data_i;
  group_vec_t debug_rsp_i;
  group_vec_t debug_req_o;
  group_vec_t debug_resume_o;
  group_vec_t setback_o;
  group_vec_t instr_lock_o;
  group_vec_t clk_en_o;
  group_vec_t pc_read_en_o;
  group_vec_t pc_write_en_o;
  group_vec_t recover_o;
  group_vec_t we_a_o;
  group_vec_t we_b_o;
  rf_addr_t   waddr_a_o;
  rf_addr_t   waddr_b_o;
  logic       intruder_lock_o;

  // reference model
  // pend1 is the start cycle, pend2 the setback cycle, locked covers the rest
  logic pend1_q;
  logic pend2_q;
  logic locked_q;
  logic req_done_q;
  logic rsp_seen_q;
  logic done_once_q;
  int   exp_grp_q;
  int   pc_cnt_q;
  int   wr_cnt_q;
  int   rec_cnt_q;
  int   err_cnt;
  int   timeout_cnt;
  int   started;
  // expected rf write step this cycle
  logic write_step;

  always #5 clk_i = ~clk_i;

  dmr_recovery_top DUT (.*);

  tb_dmr_core_model u_core_model (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .debug_req_i (debug_req_o),
    .debug_rsp_o (debug_rsp_i)
  );

  // lowest set group wins
  function automatic int lowest_group(input group_vec_t v);
    for (int i = 0; i < `DMR_NUM_GROUPS; i++) begin
      if (v[i]) begin
        return i;
      end
    end
    return 0;
  endfunction

  function automatic group_vec_t group_mask(input int idx);
    group_vec_t m;
    m      = '0;
    m[idx] = 1'b1;
    return m;
  endfunction

  // expected group's bit when cond holds
  function automatic group_vec_t faulty_if(input logic cond);
    group_vec_t m;
    m            = '0;
    m[exp_grp_q] = cond;
    return m;
  endfunction

  task automatic fail_check(input string msg);
    err_cnt++;
    $display("[FAIL] %0t: %s", $time, msg);
  endtask

  // one cycle of checker errors, one mask per line
  task automatic inject_error(input group_vec_t a, input group_vec_t b,
                              input group_vec_t m, input group_vec_t d);
    @(negedge clk_i);
    err_rf_a_i      = a;
    err_rf_b_i      = b;
    err_core_main_i = m;
    err_core_data_i = d;
    @(negedge clk_i);
    err_rf_a_i      = '0;
    err_rf_b_i      = '0;
    err_core_main_i = '0;
    err_core_data_i = '0;
  endtask

  // main output errors on two back-to-back cycles
  task automatic inject_back_to_back(input group_vec_t first, input group_vec_t second);
    @(negedge clk_i);
    err_core_main_i = first;
    @(negedge clk_i);
    err_core_main_i = second;
    @(negedge clk_i);
    err_core_main_i = '0;
  endtask

  task automatic wait_resume();
    int n;
    n = 0;
    while (debug_resume_o == '0 && n < WAIT_MAX) begin
      @(negedge clk_i);
      n++;
    end
    if (debug_resume_o == '0) begin
      timeout_cnt++;
      $display("timeout: recovery %0d never reached debug resume", started);
    end
    started++;
    @(negedge clk_i);
  endtask

  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pend1_q     <= 1'b0;
      pend2_q     <= 1'b0;
      locked_q    <= 1'b0;
      req_done_q  <= 1'b0;
      rsp_seen_q  <= 1'b0;
      done_once_q <= 1'b0;
      exp_grp_q   <= 0;
      pc_cnt_q    <= 0;
      wr_cnt_q    <= 0;
      rec_cnt_q   <= 0;
    end else begin
      pend1_q <= 1'b0;
      pend2_q <= pend1_q;
      // errors count only while nothing is pending or running
      if ((err_rf_a_i | err_rf_b_i | err_core_main_i | err_core_data_i) != '0 &&
          !pend1_q && !pend2_q && !locked_q) begin
        pend1_q   <= 1'b1;
        exp_grp_q <= lowest_group(err_rf_a_i | err_rf_b_i | err_core_main_i | err_core_data_i);
      end
      if (pend2_q) begin
        locked_q   <= 1'b1;
        req_done_q <= 1'b0;
        rsp_seen_q <= 1'b0;
        pc_cnt_q   <= 0;
        wr_cnt_q   <= 0;
      end
      if (locked_q) begin
        req_done_q <= 1'b1;
        if (req_done_q && debug_rsp_i[exp_grp_q]) begin
          rsp_seen_q <= 1'b1;
        end
        if (rsp_seen_q && pc_cnt_q < PC_CYCLES) begin
          pc_cnt_q <= pc_cnt_q + 1;
        end
        if (pc_cnt_q == PC_CYCLES && wr_cnt_q < HALF) begin
          wr_cnt_q <= wr_cnt_q + 1;
        end
        // resume cycle ends the recovery
        if (wr_cnt_q == HALF) begin
          locked_q    <= 1'b0;
          done_once_q <= 1'b1;
          rec_cnt_q   <= rec_cnt_q + 1;
        end
      end
    end
  end

  assign write_step = locked_q && pc_cnt_q == PC_CYCLES && wr_cnt_q < HALF;

  assert property (@(posedge clk_i) !rst_ni |-> (setback_o == '0 && debug_req_o == '0 &&
      debug_resume_o == '0 && pc_read_en_o == '0 && recover_o == '0 && instr_lock_o == '0 &&
      we_a_o == '0 && we_b_o == '0 && clk_en_o == '1 && pc_write_en_o == '1 &&
      !intruder_lock_o))
    else fail_check("outputs differ from their reset values during reset");
  // one setback pulse on the faulty group only
  assert property (@(posedge clk_i) disable iff (!rst_ni) setback_o == faulty_if(pend2_q))
    else fail_check("setback wrong in group or timing");
  assert property (@(posedge clk_i) disable iff (!rst_ni)
      debug_req_o == faulty_if(locked_q && !req_done_q))
    else fail_check("debug request wrong in group or timing");
  // readback only after the halt response
  assert property (@(posedge clk_i) disable iff (!rst_ni)
      pc_read_en_o == faulty_if(locked_q && rsp_seen_q && pc_cnt_q < PC_CYCLES))
    else fail_check("pc read enable wrong in group or length");
  assert property (@(posedge clk_i) disable iff (!rst_ni)
      we_a_o == faulty_if(write_step) && we_b_o == faulty_if(write_step))
    else fail_check("rf write enables wrong in group or count");
  assert property (@(posedge clk_i) disable iff (!rst_ni) write_step |->
      (waddr_a_o == rf_addr_t'(wr_cnt_q) && waddr_b_o == rf_addr_t'(wr_cnt_q + HALF)))
    else fail_check($sformatf("rf write addresses %0d/%0d, step %0d",
                              waddr_a_o, waddr_b_o, wr_cnt_q));
  assert property (@(posedge clk_i) disable iff (!rst_ni)
      recover_o == faulty_if(locked_q && pc_cnt_q == PC_CYCLES))
    else fail_check("recover wrong in group or timing");
  assert property (@(posedge clk_i) disable iff (!rst_ni)
      debug_resume_o == faulty_if(locked_q && wr_cnt_q == HALF))
    else fail_check("debug resume wrong in group or timing");
  // healthy groups clock gated while locked
  assert property (@(posedge clk_i) disable iff (!rst_ni)
      instr_lock_o == faulty_if(locked_q) &&
      clk_en_o == (locked_q ? faulty_if(1'b1) : '1) &&
      pc_write_en_o == (locked_q ? ~faulty_if(1'b1) : '1))
    else fail_check("instr lock, clock enable or pc write enable wrong");
  assert property (@(posedge clk_i) disable iff (!rst_ni) intruder_lock_o == done_once_q)
    else fail_check("intruder lock wrong");

  initial begin
    clk_i           = 1'b0;
    rst_ni          = 1'b1;
    err_rf_a_i      = '0;
    err_rf_b_i      = '0;
    err_core_main_i = '0;
    err_core_data_i = '0;
    err_cnt         = 0;
    timeout_cnt     = 0;
    started         = 0;
    #1 rst_ni = 1'b0;
    repeat (10) @(negedge clk_i);
    rst_ni = 1'b1;
    repeat (3) @(negedge clk_i);
    // each checker line on its own group
    inject_error(group_mask(2), '0, '0, '0);
    wait_resume();
    inject_error('0, group_mask(1), '0, '0);
    wait_resume();
    inject_error('0, '0, group_mask(0), '0);
    wait_resume();
    inject_error('0, '0, '0, group_mask(3));
    wait_resume();
    // two groups in one cycle and the lower index is repaired
    inject_error(group_mask(3), '0, '0, group_mask(1));
    wait_resume();
    // second error arrives mid-recovery and is dropped
    inject_error('0, '0, group_mask(2), '0);
    repeat (4) @(negedge clk_i);
    inject_error(group_mask(0), '0, '0, '0);
    wait_resume();
    // next-cycle error meets the start strobe and is dropped
    inject_back_to_back(group_mask(3), group_mask(0));
    wait_resume();
    // a stray recovery would show up here
    repeat (100) @(negedge clk_i);
    if (rec_cnt_q != started) begin
      fail_check($sformatf("%0d recoveries completed, expected %0d", rec_cnt_q, started));
    end
    $display("recoveries %0d, errors %0d, timeouts %0d", rec_cnt_q, err_cnt, timeout_cnt);
    if (err_cnt == 0 && timeout_cnt == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

/* tests/tb_dmr_core_model.sv */
// dmr core debug model that answers each halt request after a random delay
`timescale 1ns/100ps

`include "dmr_recovery_cfg.svh"

module tb_dmr_core_model (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  dmr_recovery_pkg::group_vec_t debug_req_i,
  output dmr_recovery_pkg::group_vec_t debug_rsp_o
);

  import dmr_recovery_pkg::*;

  // longest halt latency in cycles
  localparam int MAX_DELAY = 8;

  integer     seed = 69283;
  // cycles left until each group answers
  int         remaining [`DMR_NUM_GROUPS] = '{default: 0};
  group_vec_t rsp_q = '0;

  // driven on the falling edge
  // a request seen in one cycle is answered 1 to MAX_DELAY cycles later
  always @(negedge clk_i) begin
    if (!rst_ni) begin
      rsp_q = '0;
      for (int i = 0; i < `DMR_NUM_GROUPS; i++) begin
        remaining[i] = 0;
      end
    end else begin
      for (int i = 0; i < `DMR_NUM_GROUPS; i++) begin
        rsp_q[i] = 1'b0;
        if (remaining[i] != 0) begin
          remaining[i] = remaining[i] - 1;
          // response is a one-cycle strobe
          if (remaining[i] == 0) begin
            rsp_q[i] = 1'b1;
          end
        end
        if (debug_req_i[i]) begin
          remaining[i] = 1 + int'($unsigned($random(seed)) % MAX_DELAY);
        end
      end
    end
  end

  assign debug_rsp_o = rsp_q;

endmodule

/* rtl/dmr_recovery_top.sv */
// dmr recovery controller top chaining capture, sequencer and rf restore
`timescale 1ns/100ps

module dmr_recovery_top (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  // checker mismatch levels
  input  dmr_recovery_pkg::group_vec_t err_rf_a_i,
  input  dmr_recovery_pkg::group_vec_t err_rf_b_i,
  input  dmr_recovery_pkg::group_vec_t err_core_main_i,
  input  dmr_recovery_pkg::group_vec_t err_core_data_i,
  // core debug handshake
  input  dmr_recovery_pkg::group_vec_t debug_rsp_i,
  output dmr_recovery_pkg::group_vec_t debug_req_o,
  output dmr_recovery_pkg::group_vec_t debug_resume_o,
  // core control
  output dmr_recovery_pkg::group_vec_t setback_o,
  output dmr_recovery_pkg::group_vec_t instr_lock_o,
  output dmr_recovery_pkg::group_vec_t clk_en_o,
  output dmr_recovery_pkg::group_vec_t pc_read_en_o,
  output dmr_recovery_pkg::group_vec_t pc_write_en_o,
  output dmr_recovery_pkg::group_vec_t recover_o,
  // register file write ports
  output dmr_recovery_pkg::group_vec_t we_a_o,
  output dmr_recovery_pkg::group_vec_t we_b_o,
  output dmr_recovery_pkg::rf_addr_t   waddr_a_o,
  output dmr_recovery_pkg::rf_addr_t   waddr_b_o,
  output logic                         intruder_lock_o
);

  import dmr_recovery_pkg::*;

  // capture to sequencer
  logic       start;
  logic       busy;
  // latched faulty group for sequencer and restore
  group_idx_t group_idx;
  // sequencer to restore
  logic       restore_en;
  logic       restore_done;

  dmr_error_capture u_capture (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .err_rf_a_i      (err_rf_a_i),
    .err_rf_b_i      (err_rf_b_i),
    .err_core_main_i (err_core_main_i),
    .err_core_data_i (err_core_data_i),
    .busy_i          (busy),
    .start_o         (start),
    .group_o         (group_idx)
  );

  dmr_recovery_seq u_seq (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .start_i         (start),
    .group_i         (group_idx),
    .debug_rsp_i     (debug_rsp_i),
    .restore_done_i  (restore_done),
    .busy_o          (busy),
    .restore_en_o    (restore_en),
    .setback_o       (setback_o),
    .instr_lock_o    (instr_lock_o),
    .clk_en_o        (clk_en_o),
    .debug_req_o     (debug_req_o),
    .debug_resume_o  (debug_resume_o),
    .pc_read_en_o    (pc_read_en_o),
    .pc_write_en_o   (pc_write_en_o),
    .recover_o       (recover_o),
    .intruder_lock_o (intruder_lock_o)
  );

  dmr_rf_restore u_restore (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .restore_en_i   (restore_en),
    .group_i        (group_idx),
    .restore_done_o (restore_done),
    .we_a_o         (we_a_o),
    .we_b_o         (we_b_o),
    .waddr_a_o      (waddr_a_o),
    .waddr_b_o      (waddr_b_o)
  );

endmodule

/* rtl/dmr_rf_restore.sv */
// dmr register file restore with address generator and write port router
`timescale 1ns/100ps

`include "dmr_recovery_cfg.svh"

module dmr_rf_restore (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         restore_en_i,
  input  dmr_recovery_pkg::group_idx_t group_i,
  output logic                         restore_done_o,
  output dmr_recovery_pkg::group_vec_t we_a_o,
  output dmr_recovery_pkg::group_vec_t we_b_o,
  output dmr_recovery_pkg::rf_addr_t   waddr_a_o,
  output dmr_recovery_pkg::rf_addr_t   waddr_b_o
);

  import dmr_recovery_pkg::*;

  // restore steps
  // port a covers the lower half and port b the upper half
  localparam int unsigned HALF = 1 << (`DMR_RF_ADDR_WIDTH - 1);

  rf_addr_t   step_q;
  logic       last_step;
  // one-hot of the target group
  group_vec_t group_sel;

  assign last_step = (step_q == rf_addr_t'(HALF - 1));

  // done on the cycle the last address goes out
  assign restore_done_o = restore_en_i && last_step;

  // address counter
  // clears after the last step and whenever the enable is low
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      step_q <= '0;
    end else if (restore_en_i && !last_step) begin
      step_q <= step_q + 1'b1;
    end else begin
      step_q <= '0;
    end
  end

  // target group decode
  always_comb begin
    group_sel          = '0;
    group_sel[group_i] = 1'b1;
  end

  // write enables only toward the faulty group
  assign we_a_o = restore_en_i ? group_sel : '0;
  assign we_b_o = restore_en_i ? group_sel : '0;

  // addresses shared by all groups
  assign waddr_a_o = step_q;
  assign waddr_b_o = step_q + rf_addr_t'(HALF);

endmodule

/* rtl/dmr_recovery_seq.sv */
// dmr recovery sequencer FSM driving per-group core control during recovery
`timescale 1ns/100ps

`include "dmr_recovery_cfg.svh"

module dmr_recovery_seq (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         start_i,
  input  dmr_recovery_pkg::group_idx_t group_i,
  input  dmr_recovery_pkg::group_vec_t debug_rsp_i,
  input  logic                         restore_done_i,
  output logic                         busy_o,
  output logic                         restore_en_o,
  output dmr_recovery_pkg::group_vec_t setback_o,
  output dmr_recovery_pkg::group_vec_t instr_lock_o,
  output dmr_recovery_pkg::group_vec_t clk_en_o,
  output dmr_recovery_pkg::group_vec_t debug_req_o,
  output dmr_recovery_pkg::group_vec_t debug_resume_o,
  output dmr_recovery_pkg::group_vec_t pc_read_en_o,
  output dmr_recovery_pkg::group_vec_t pc_write_en_o,
  output dmr_recovery_pkg::group_vec_t recover_o,
  output logic                         intruder_lock_o
);

  import dmr_recovery_pkg::*;

  // pc readback length
  localparam int unsigned PC_CYCLES = `DMR_PC_RESTORE_CYCLES;
  localparam int unsigned PC_CNT_W  = (PC_CYCLES > 1) ? $clog2(PC_CYCLES) : 1;

  recovery_state_e state_q;
  recovery_state_e state_d;

  // one-hot select of the faulty group
  group_vec_t group_sel;

  // pc readback counter
  logic [PC_CNT_W-1:0] pc_cnt_q;
  logic                pc_last;

  // registered per-group levels
  group_vec_t instr_lock_q;
  group_vec_t clk_en_q;
  group_vec_t pc_write_en_q;
  group_vec_t recover_q;
  logic       intruder_lock_q;

  // decode latched index
  always_comb begin
    group_sel          = '0;
    group_sel[group_i] = 1'b1;
  end

  // last readback cycle
  assign pc_last = (pc_cnt_q == PC_CNT_W'(PC_CYCLES - 1));

  // next state
  always_comb begin
    state_d = state_q;
    unique case (state_q)
      IDLE: begin
        if (start_i) begin
          state_d = SETBACK;
        end
      end
      // setback lasts one cycle
      SETBACK: begin
        state_d = HALT_REQ;
      end
      // single debug request pulse
      HALT_REQ: begin
        state_d = HALT_WAIT;
      end
      // core latency varies
      // only the faulty group's response counts
      HALT_WAIT: begin
        if (debug_rsp_i[group_i]) begin
          state_d = RESTORE_PC;
        end
      end
      RESTORE_PC: begin
        if (pc_last) begin
          state_d = RESTORE_RF;
        end
      end
      // address generator flags its last step
      RESTORE_RF: begin
        if (restore_done_i) begin
          state_d = RESUME;
        end
      end
      RESUME: begin
        state_d = IDLE;
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  // state register
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // counts readback cycles
  // cleared on leaving restore_pc so the next recovery starts from zero
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pc_cnt_q <= '0;
    end else if (state_q == RESTORE_PC && !pc_last) begin
      pc_cnt_q <= pc_cnt_q + 1'b1;
    end else begin
      pc_cnt_q <= '0;
    end
  end

  // per-group levels
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      instr_lock_q    <= '0;
      clk_en_q        <= '1;
      pc_write_en_q   <= '1;
      recover_q       <= '0;
      intruder_lock_q <= 1'b0;
    end else begin
      case (state_q)
        // lock fetch and freeze the saved pc of the faulty group
        // healthy groups are clock gated from the next cycle on
        SETBACK: begin
          instr_lock_q  <= group_sel;
          pc_write_en_q <= ~group_sel;
          clk_en_q      <= group_sel;
        end
        // recover rises together with the first rf write
        RESTORE_PC: begin
          if (pc_last) begin
            recover_q <= group_sel;
          end
        end
        // release everything at the end of resume
        RESUME: begin
          instr_lock_q    <= '0;
          clk_en_q        <= '1;
          pc_write_en_q   <= '1;
          recover_q       <= '0;
          intruder_lock_q <= 1'b1;
        end
        default: begin
          instr_lock_q <= instr_lock_q;
        end
      endcase
    end
  end

  // strobes decoded for the faulty group
  assign setback_o      = (state_q == SETBACK)    ? group_sel : '0;
  assign debug_req_o    = (state_q == HALT_REQ)   ? group_sel : '0;
  assign pc_read_en_o   = (state_q == RESTORE_PC) ? group_sel : '0;
  assign debug_resume_o = (state_q == RESUME)     ? group_sel : '0;

  // handshake levels toward capture and restore
  assign busy_o       = (state_q != IDLE);
  assign restore_en_o = (state_q == RESTORE_RF);

  assign instr_lock_o    = instr_lock_q;
  assign clk_en_o        = clk_en_q;
  assign pc_write_en_o   = pc_write_en_q;
  assign recover_o       = recover_q;
  // sticky until reset
  assign intruder_lock_o = intruder_lock_q;

endmodule

/* rtl/dmr_error_capture.sv */
// dmr error capture that merges checker lines and latches the faulty group
`timescale 1ns/100ps

`include "dmr_recovery_cfg.svh"

module dmr_error_capture (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  dmr_recovery_pkg::group_vec_t err_rf_a_i,
  input  dmr_recovery_pkg::group_vec_t err_rf_b_i,
  input  dmr_recovery_pkg::group_vec_t err_core_main_i,
  input  dmr_recovery_pkg::group_vec_t err_core_data_i,
  input  logic                         busy_i,
  output logic                         start_o,
  output dmr_recovery_pkg::group_idx_t group_o
);

  import dmr_recovery_pkg::*;

  // merged mismatch per group
  group_vec_t err_any;
  // lowest faulty group this cycle
  group_idx_t err_idx;
  // new recovery accepted this cycle
  logic       accept;

  logic       start_q;
  group_idx_t group_q;

  // any checker line flags its group
  assign err_any = err_rf_a_i | err_rf_b_i | err_core_main_i | err_core_data_i;

  // priority encoder
  // scan downward so the lowest set index is the last one written
  always_comb begin
    err_idx = '0;
    for (int i = `DMR_NUM_GROUPS - 1; i >= 0; i--) begin
      if (err_any[i]) begin
        err_idx = group_idx_t'(i);
      end
    end
  end

  // only one recovery in flight
  // the strobe cycle itself is blocked since busy rises one edge later
  assign accept = (|err_any) && !busy_i && !start_q;

  // start strobe and latched index
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      start_q <= 1'b0;
      group_q <= '0;
    end else begin
      start_q <= accept;
      // index held until the next capture
      if (accept) begin
        group_q <= err_idx;
      end
    end
  end

  assign start_o = start_q;
  assign group_o = group_q;

endmodule

/* rtl/dmr_recovery_pkg.sv */
// dmr recovery types for the state machine, group vectors and rf addresses
package dmr_recovery_pkg;

  `include "dmr_recovery_cfg.svh"

  // width of a group index
  // at least one bit even for a single group
  localparam int unsigned GROUP_IDX_W =
    (`DMR_NUM_GROUPS > 1) ? $clog2(`DMR_NUM_GROUPS) : 1;

  // recovery sequence states in execution order
  typedef enum logic [2:0] {
    IDLE,
    SETBACK,
    HALT_REQ,
    HALT_WAIT,
    RESTORE_PC,
    RESTORE_RF,
    RESUME
  } recovery_state_e;

  // one bit per group
  typedef logic [`DMR_NUM_GROUPS-1:0] group_vec_t;

  // index of one group
  typedef logic [GROUP_IDX_W-1:0] group_idx_t;

  // register file write address
  typedef logic [`DMR_RF_ADDR_WIDTH-1:0] rf_addr_t;

endpackage

/* rtl/dmr_recovery_cfg.svh */
// dmr recovery controller configuration macros shared by package and rtl
`ifndef DMR_RECOVERY_CFG_SVH
`define DMR_RECOVERY_CFG_SVH

// number of dual modular redundancy groups
// one group holds two lockstepped cores
`define DMR_NUM_GROUPS 4

// register file address width
// restore walks half the depth and writes two ports per step
`define DMR_RF_ADDR_WIDTH 6

// cycles the saved program counter is read back
`define DMR_PC_RESTORE_CYCLES 2

`endif
